// File: source/alut_defs.svh
// ------------------------------------------------
// field widths of the lookup table, all in bits
// table depth follows from the hash width
// ------------------------------------------------
`ifndef ALUT_DEFS_SVH
`define ALUT_DEFS_SVH

`define ALUT_ADDR_W   48                   // ethernet mac address
`define ALUT_PORT_W   2                    // encoded port, four ports
`define ALUT_TIME_W   32                   // timestamp and max age
`define ALUT_HASH_W   8                    // xor of the address bytes
`define ALUT_ENTRY_W  83                   // valid + time + port + address
`define ALUT_DPORT_W  5                    // one-hot ports plus own-mac bit

// one entry per hash value
`define ALUT_DEPTH    (1 << `ALUT_HASH_W)

`endif

// File: source/alut_pkg.sv
// ------------------------------------------------
// shared types of the lookup table
// entry layout is fixed, valid bit on top
// ------------------------------------------------
`include "alut_defs.svh"

package alut_pkg;

   // one table entry, top bit down
   typedef struct packed
   {
      logic                      valid;       // entry has been learned
      logic [`ALUT_TIME_W-1:0]   last_time;   // time of last learn
      logic [`ALUT_PORT_W-1:0]   port;        // port the address came in on
      logic [`ALUT_ADDR_W-1:0]   addr;        // learned source address
   } alut_entry_t;

   // software command codes
   typedef enum logic [1:0]
   {
      cmd_none       = 2'd0,
      cmd_check      = 2'd1,   // lookup and learn
      cmd_clr_reused = 2'd2,   // clear sticky reused flag
      cmd_set_age    = 2'd3    // load max age from cmd_data
   } alut_cmd_e;

   // address checker states, encoded for waveform reading
   typedef enum logic [2:0]
   {
      st_idle      = 3'd0,
      st_mac_chk   = 3'd1,
      st_read_dest = 3'd2,
      st_valid_chk = 3'd3,
      st_age_chk   = 3'd4,
      st_addr_chk  = 3'd5,
      st_read_src  = 3'd6,
      st_write_src = 3'd7
   } alut_chk_state_e;

endpackage

// File: source/alut_cmd_decode.sv
// ------------------------------------------------
// command strobe decode with one cycle of latency
// a check arriving while busy is dropped and flagged
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_cmd_decode
(
   input  logic                      pclk24,
   input  logic                      n_p_reset24,
   input  logic                      cmd_write,      // one-cycle command strobe
   input  alut_pkg::alut_cmd_e       cmd,
   input  logic [`ALUT_TIME_W-1:0]   cmd_data,       // max age for set age
   input  logic                      check_busy,
   output logic                      check_start,    // one-cycle pulse to checker
   output logic                      clear_reused,   // one-cycle pulse to result
   output logic [`ALUT_TIME_W-1:0]   max_age,
   output logic                      cmd_dropped     // sticky overload flag
);
   import alut_pkg::*;

   logic chk_cmd;      // check command this cycle
   logic chk_blocked;  // checker cannot take a new start

   assign chk_cmd     = cmd_write && (cmd == cmd_check);
   assign chk_blocked = check_busy || check_start;   // start already in flight counts

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         check_start  <= 1'b0;
         clear_reused <= 1'b0;
         max_age      <= '0;
         cmd_dropped  <= 1'b0;
      end
      else
      begin
         check_start  <= chk_cmd && !chk_blocked;
         clear_reused <= cmd_write && (cmd == cmd_clr_reused);
         if (cmd_write && (cmd == cmd_set_age))
            max_age <= cmd_data;
         if (chk_cmd && chk_blocked)
            cmd_dropped <= 1'b1;                       // lost check that sw must retry
         else if (cmd_write && (cmd == cmd_clr_reused))
            cmd_dropped <= 1'b0;
      end
   end

   // a start pulse is taken up by the checker on the next cycle
   a_start_taken : assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      check_start |=> check_busy);

endmodule

// File: source/alut_addr_checker.sv
// ------------------------------------------------
// lookup of d_addr, then learn of s_addr and s_port
// address inputs must stay stable while check_busy
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_addr_checker
(
   input  logic                      pclk24,
   input  logic                      n_p_reset24,
   input  logic                      check_start,
   input  logic [`ALUT_ADDR_W-1:0]   mac_addr,       // own switch address
   input  logic [`ALUT_ADDR_W-1:0]   d_addr,         // destination to look up
   input  logic [`ALUT_ADDR_W-1:0]   s_addr,         // source to learn
   input  logic [`ALUT_PORT_W-1:0]   s_port,
   input  logic [`ALUT_TIME_W-1:0]   curr_time,
   input  alut_pkg::alut_entry_t     mem_rdata,      // one cycle after mem_addr
   input  logic                      age_confirmed,
   input  logic                      age_ok,
   output logic                      check_busy,
   output logic [`ALUT_HASH_W-1:0]   mem_addr,
   output logic                      mem_write,
   output alut_pkg::alut_entry_t     mem_wdata,
   output logic                      check_age,      // one-cycle age request
   output logic [`ALUT_TIME_W-1:0]   last_accessed,
   output logic                      port_load,
   output logic [`ALUT_DPORT_W-1:0]  port_vec,
   output logic                      evict,
   output logic [`ALUT_ADDR_W-1:0]   evict_addr,
   output logic [`ALUT_PORT_W-1:0]   evict_port
);
   import alut_pkg::*;

   alut_chk_state_e             state;
   alut_chk_state_e             nxt_state;
   logic [`ALUT_HASH_W-1:0]     d_hash;
   logic [`ALUT_HASH_W-1:0]     s_hash;
   logic                        mac_match;
   logic                        dest_hit;     // valid, in date and same address
   logic                        age_req;
   logic [`ALUT_DPORT_W-1:0]    stored_vec;   // one-hot of the stored port
   logic [`ALUT_DPORT_W-1:0]    src_vec;      // one-hot of the source port

   // xor of all address bytes
   function automatic logic [`ALUT_HASH_W-1:0] addr_hash(input logic [`ALUT_ADDR_W-1:0] a);
      logic [`ALUT_HASH_W-1:0] h;
      h = '0;
      for (int i = 0; i < `ALUT_ADDR_W / `ALUT_HASH_W; i++)
         h = h ^ a[i*`ALUT_HASH_W +: `ALUT_HASH_W];
      return h;
   endfunction

   assign d_hash    = addr_hash(d_addr);
   assign s_hash    = addr_hash(s_addr);
   assign mac_match = (d_addr == mac_addr);

   // ------------------------------------------------
   // state sequence
   // ------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         st_idle      : if (check_start) nxt_state = st_mac_chk;
         st_mac_chk   : nxt_state = mac_match ? st_idle : st_read_dest;
         st_read_dest : nxt_state = st_valid_chk;
         st_valid_chk : nxt_state = st_age_chk;
         st_age_chk   : if (age_confirmed) nxt_state = st_addr_chk;  // wait for answer
         st_addr_chk  : nxt_state = st_read_src;
         st_read_src  : nxt_state = st_write_src;
         st_write_src : nxt_state = st_idle;
         default      : nxt_state = st_idle;
      endcase
   end

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         state <= st_idle;
      else
         state <= nxt_state;
   end

   assign check_busy = (state != st_idle);

   // ------------------------------------------------
   // memory side
   // ------------------------------------------------
   // destination hash until the learn phase, so rdata holds the dest entry
   assign mem_addr  = ((state == st_read_src) || (state == st_write_src)) ? s_hash : d_hash;
   assign mem_write = (state == st_write_src);
   assign mem_wdata = {1'b1, curr_time, s_port, s_addr};   // learned entries always valid

   // old entry at the source hash is in rdata during write_src
   assign evict      = (state == st_write_src) && mem_rdata.valid && (mem_rdata.addr != s_addr);
   assign evict_addr = mem_rdata.addr;
   assign evict_port = mem_rdata.port;

   // ------------------------------------------------
   // age request goes out one cycle into age_chk
   // ------------------------------------------------
   assign age_req = (state == st_age_chk) && !check_age && !age_confirmed;

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         check_age <= 1'b0;
      else
         check_age <= age_req;
   end

   always_ff @(posedge pclk24)
   begin
      if (age_req)
         last_accessed <= mem_rdata.last_time;   // timestamp of the dest entry
   end

   // ------------------------------------------------
   // destination port vector
   // ------------------------------------------------
   always_comb
   begin
      stored_vec = '0;
      src_vec    = '0;
      stored_vec[mem_rdata.port] = 1'b1;
      src_vec[s_port]            = 1'b1;
   end

   assign dest_hit = mem_rdata.valid && age_ok && (mem_rdata.addr == d_addr);

   always_comb
   begin
      if (state == st_mac_chk)
         port_vec = {1'b1, {(`ALUT_DPORT_W-1){1'b0}}};          // frame for the switch
      else if (dest_hit)
         port_vec = stored_vec & ~src_vec;                      // may be all zero
      else
         port_vec = {1'b0, {(`ALUT_DPORT_W-1){1'b1}}} & ~src_vec;   // flood
   end

   assign port_load = ((state == st_mac_chk) && mac_match) || (state == st_addr_chk);

   // ------------------------------------------------
   // checks
   // ------------------------------------------------
   // age checker answers exactly one cycle after the request
   a_age_answer : assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      check_age |=> age_confirmed);

   // age checker answer must land while we wait for it
   a_age_in_state : assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      age_confirmed |-> (state == st_age_chk));

   // a start never reaches a running check
   a_start_idle : assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      check_start |-> (state == st_idle));

endmodule

// File: source/alut_age_checker.sv
// ------------------------------------------------
// in-date check, answer one cycle after check_age
// time difference is taken modulo 2^32
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_age_checker
(
   input  logic                      pclk24,
   input  logic                      n_p_reset24,
   input  logic                      check_age,       // request pulse
   input  logic [`ALUT_TIME_W-1:0]   last_accessed,   // stored timestamp
   input  logic [`ALUT_TIME_W-1:0]   curr_time,
   input  logic [`ALUT_TIME_W-1:0]   max_age,
   output logic                      age_confirmed,   // answer pulse
   output logic                      age_ok           // level, held until next request
);

   logic [`ALUT_TIME_W-1:0] age;   // elapsed time, wrap safe

   assign age = curr_time - last_accessed;

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         if (check_age)
            age_ok <= (age < max_age);   // max_age of 0 ages everything out
      end
   end

endmodule

// File: source/alut_mem.sv
// ------------------------------------------------
// single port table, read data one cycle after addr
// valid bits reset, payload comes up undefined
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_mem
(
   input  logic                      pclk24,
   input  logic                      n_p_reset24,
   input  logic [`ALUT_HASH_W-1:0]   mem_addr,
   input  logic                      mem_write,
   input  alut_pkg::alut_entry_t     mem_wdata,
   output alut_pkg::alut_entry_t     mem_rdata
);

   logic [`ALUT_ENTRY_W-2:0]  data_q [`ALUT_DEPTH];   // time, port, address
   logic [`ALUT_DEPTH-1:0]    valid_q;                // one valid bit per entry
   logic [`ALUT_ENTRY_W-2:0]  rd_data_q;
   logic                      rd_valid_q;

   // payload array
   always_ff @(posedge pclk24)
   begin
      if (mem_write)
         data_q[mem_addr] <= mem_wdata[`ALUT_ENTRY_W-2:0];
      rd_data_q <= data_q[mem_addr];   // read before write, old data
   end

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         valid_q    <= '0;
         rd_valid_q <= 1'b0;
      end
      else
      begin
         if (mem_write)
            valid_q[mem_addr] <= mem_wdata.valid;
         rd_valid_q <= valid_q[mem_addr];
      end
   end

   assign mem_rdata = {rd_valid_q, rd_data_q};

endmodule

// File: source/alut_result.sv
// ------------------------------------------------
// result registers read by software
// evict wins over clear in the same cycle
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_result
(
   input  logic                      pclk24,
   input  logic                      n_p_reset24,
   input  logic                      port_load,
   input  logic [`ALUT_DPORT_W-1:0]  port_vec,
   input  logic                      evict,
   input  logic [`ALUT_ADDR_W-1:0]   evict_addr,
   input  logic [`ALUT_PORT_W-1:0]   evict_port,
   input  logic                      clear_reused,
   output logic [`ALUT_DPORT_W-1:0]  d_port,         // last destination vector
   output logic                      reused,         // sticky, read and clear
   output logic [`ALUT_ADDR_W-1:0]   lst_inv_addr,   // last evicted address
   output logic [`ALUT_PORT_W-1:0]   lst_inv_port    // and its port
);

   // ------------------------------------------------
   // destination port
   // ------------------------------------------------
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         d_port <= {1'b0, {(`ALUT_DPORT_W-1){1'b1}}};   // flood until first check
      else if (port_load)
         d_port <= port_vec;
   end

   // ------------------------------------------------
   // eviction record
   // ------------------------------------------------
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (evict)
      begin
         reused       <= 1'b1;
         lst_inv_addr <= evict_addr;
         lst_inv_port <= evict_port;
      end
      else if (clear_reused)
      begin
         reused <= 1'b0;   // address and port stay for software
      end
   end

endmodule

// File: source/alut_top.sv
// ------------------------------------------------
// control side of the address lookup table
// d_addr, s_addr, s_port, mac_addr held while busy
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_top
(
   input  logic                      pclk24,
   input  logic                      n_p_reset24,
   input  logic                      cmd_write,
   input  alut_pkg::alut_cmd_e       cmd,
   input  logic [`ALUT_TIME_W-1:0]   cmd_data,
   input  logic [`ALUT_ADDR_W-1:0]   mac_addr,
   input  logic [`ALUT_ADDR_W-1:0]   d_addr,
   input  logic [`ALUT_ADDR_W-1:0]   s_addr,
   input  logic [`ALUT_PORT_W-1:0]   s_port,
   input  logic [`ALUT_TIME_W-1:0]   curr_time,
   output logic                      check_busy,
   output logic                      cmd_dropped,
   output logic [`ALUT_DPORT_W-1:0]  d_port,
   output logic                      reused,
   output logic [`ALUT_ADDR_W-1:0]   lst_inv_addr,
   output logic [`ALUT_PORT_W-1:0]   lst_inv_port
);
   import alut_pkg::*;

   // ------------------------------------------------
   // internal nets
   // ------------------------------------------------
   logic                      check_start;
   logic                      clear_reused;
   logic [`ALUT_TIME_W-1:0]   max_age;
   logic [`ALUT_HASH_W-1:0]   mem_addr;
   logic                      mem_write;
   alut_entry_t               mem_wdata;
   alut_entry_t               mem_rdata;
   logic                      check_age;
   logic [`ALUT_TIME_W-1:0]   last_accessed;
   logic                      age_confirmed;
   logic                      age_ok;
   logic                      port_load;
   logic [`ALUT_DPORT_W-1:0]  port_vec;
   logic                      evict;
   logic [`ALUT_ADDR_W-1:0]   evict_addr;
   logic [`ALUT_PORT_W-1:0]   evict_port;

   alut_cmd_decode u_decode (.pclk24, .n_p_reset24, .cmd_write, .cmd, .cmd_data,
      .check_busy, .check_start, .clear_reused, .max_age, .cmd_dropped);

   alut_addr_checker u_checker (.pclk24, .n_p_reset24, .check_start, .mac_addr,
      .d_addr, .s_addr, .s_port, .curr_time, .mem_rdata, .age_confirmed, .age_ok,
      .check_busy, .mem_addr, .mem_write, .mem_wdata, .check_age, .last_accessed,
      .port_load, .port_vec, .evict, .evict_addr, .evict_port);

   alut_age_checker u_age (.pclk24, .n_p_reset24, .check_age, .last_accessed,
      .curr_time, .max_age, .age_confirmed, .age_ok);

   alut_mem u_mem (.pclk24, .n_p_reset24, .mem_addr, .mem_write, .mem_wdata,
      .mem_rdata);

   alut_result u_result (.pclk24, .n_p_reset24, .port_load, .port_vec, .evict,
      .evict_addr, .evict_port, .clear_reused, .d_port, .reused, .lst_inv_addr,
      .lst_inv_port);

endmodule

// File: tests/alut_clk_gen.sv
// ------------------------------------------------
// 10 ns clock, reset low for the first 4 cycles
// reset is released on a falling edge
// ------------------------------------------------
`timescale 1ns/1ps

module alut_clk_gen
(
   output logic pclk24,
   output logic n_p_reset24
);

   initial
   begin
      pclk24 = 1'b0;
      forever #5 pclk24 = ~pclk24;   // first rise at 5 ns
   end

   initial
   begin
      n_p_reset24 = 1'b0;
      repeat (4) @(posedge pclk24);
      @(negedge pclk24);              // 40 ns, away from the sampling edge
      n_p_reset24 = 1'b1;
   end

endmodule

// File: tests/alut_tb.sv
// ------------------------------------------------
// ALUT testbench reading ops from tests/alut_testdata.txt
// must be run from the project root
// ------------------------------------------------
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_tb;
   import alut_pkg::*;

   localparam logic [3:0] op_peek    = 4'd0;   // compare outputs only
   localparam logic [3:0] op_check   = 4'd1;
   localparam logic [3:0] op_clear   = 4'd2;
   localparam logic [3:0] op_set_age = 4'd3;
   localparam logic [3:0] op_overlap = 4'd4;   // check plus a second strobe while busy

   // one line of testdata
   typedef struct packed
   {
      logic [3:0]                 op;
      logic [`ALUT_ADDR_W-1:0]    mac;
      logic [`ALUT_ADDR_W-1:0]    d_addr;
      logic [`ALUT_ADDR_W-1:0]    s_addr;
      logic [`ALUT_PORT_W-1:0]    s_port;
      logic [`ALUT_TIME_W-1:0]    ctime;
      logic [`ALUT_TIME_W-1:0]    cdata;
      logic [`ALUT_DPORT_W-1:0]   dport;      // expected outputs from here down
      logic                       reused;
      logic [`ALUT_ADDR_W-1:0]    lst_addr;
      logic [`ALUT_PORT_W-1:0]    lst_port;
   } op_t;

   logic                      pclk24;
   logic                      n_p_reset24;
   logic                      cmd_write;
   alut_cmd_e                 cmd;
   logic [`ALUT_TIME_W-1:0]   cmd_data;
   logic [`ALUT_ADDR_W-1:0]   mac_addr;
   logic [`ALUT_ADDR_W-1:0]   d_addr;
   logic [`ALUT_ADDR_W-1:0]   s_addr;
   logic [`ALUT_PORT_W-1:0]   s_port;
   logic [`ALUT_TIME_W-1:0]   curr_time;
   logic                      check_busy;
   logic                      cmd_dropped;
   logic [`ALUT_DPORT_W-1:0]  d_port;
   logic                      reused;
   logic [`ALUT_ADDR_W-1:0]   lst_inv_addr;
   logic [`ALUT_PORT_W-1:0]   lst_inv_port;

   op_t                       ops[$];
   int                        errors;
   bit                        loaded = 1'b0;
   logic                      exp_dropped;   // set by an overlapping check, cleared by clear
   logic                      last_reused;
   logic [`ALUT_DEPTH-1:0]    seen;          // hashes that hold a learned entry
   logic [31:0]               rng;

   alut_clk_gen u_clk (.pclk24, .n_p_reset24);

   alut_top u_dut (.pclk24, .n_p_reset24, .cmd_write, .cmd, .cmd_data, .mac_addr, .d_addr,
      .s_addr, .s_port, .curr_time, .check_busy, .cmd_dropped, .d_port, .reused,
      .lst_inv_addr, .lst_inv_port);

   // ------------------------------------------------
   // helpers
   // ------------------------------------------------
   // table index is the xor of the six address bytes
   function automatic logic [`ALUT_HASH_W-1:0] addr_hash(input logic [`ALUT_ADDR_W-1:0] a);
      return a[47:40] ^ a[39:32] ^ a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic load_testdata();
      int          fd;
      int          n;
      int          rc;
      string       line;
      logic [63:0] f [11];
      op_t         o;
      fd = $fopen("tests/alut_testdata.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("cannot open tests/alut_testdata.txt");
         return;
      end
      while (!$feof(fd))
      begin
         rc = $fgets(line, fd);
         if (rc > 1 && line.getc(0) != 8'h23)   // skip '#' lines
         begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
               f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n == 11)
            begin
               o.op       = f[0][3:0];
               o.mac      = f[1][47:0];
               o.d_addr   = f[2][47:0];
               o.s_addr   = f[3][47:0];
               o.s_port   = f[4][1:0];
               o.ctime    = f[5][31:0];
               o.cdata    = f[6][31:0];
               o.dport    = f[7][4:0];
               o.reused   = f[8][0];
               o.lst_addr = f[9][47:0];
               o.lst_port = f[10][1:0];
               ops.push_back(o);
            end
         end
      end
      $fclose(fd);
      if (ops.size() == 0)
      begin
         errors++;
         $display("testdata holds no operations");
      end
   endtask

   // one strobe on a falling edge
   task automatic issue_cmd(input alut_cmd_e code, input logic [31:0] data);
      cmd       = code;
      cmd_data  = data;
      cmd_write = 1'b1;
      @(negedge pclk24);
      cmd_write = 1'b0;
   endtask

   task automatic run_check(input op_t o);
      int wait_cnt;
      int busy_cnt;
      int exp_busy;
      wait_cnt = 0;
      busy_cnt = 0;
      exp_busy = (o.d_addr == o.mac) ? 1 : 9;   // own mac skips lookup and learn
      issue_cmd(cmd_check, o.cdata);
      while (!check_busy && wait_cnt < 8)
      begin
         @(negedge pclk24);
         wait_cnt++;
      end
      if (!check_busy)
      begin
         errors++;
         $display("check_busy never rose after a check command");
      end
      else
      begin
         while (check_busy && busy_cnt < 20)
         begin
            busy_cnt++;
            cmd_write = (o.op == op_overlap) && (busy_cnt == 2);   // must be dropped
            @(negedge pclk24);
         end
         cmd_write = 1'b0;
         if (busy_cnt != exp_busy)
         begin
            errors++;
            $display("[FAIL] check_busy cycles: expected %h, got %h", exp_busy, busy_cnt);
         end
      end
      // a new eviction needs a learned entry at the source hash
      if (o.d_addr != o.mac)
      begin
         if (reused && !last_reused && !seen[addr_hash(o.s_addr)])
         begin
            errors++;
            $display("reused was set by a source hash that was never learned");
         end
         seen[addr_hash(o.s_addr)] = 1'b1;
      end
   endtask

   task automatic check_results(input int idx, input op_t o);
      if (d_port !== o.dport)
      begin
         errors++;
         $display("[FAIL] op %0d d_port: expected %h, got %h", idx, o.dport, d_port);
      end
      if (reused !== o.reused)
      begin
         errors++;
         $display("[FAIL] op %0d reused: expected %h, got %h", idx, o.reused, reused);
      end
      if (lst_inv_addr !== o.lst_addr)
      begin
         errors++;
         $display("[FAIL] op %0d lst_inv_addr: expected %h, got %h", idx, o.lst_addr,
            lst_inv_addr);
      end
      if (lst_inv_port !== o.lst_port)
      begin
         errors++;
         $display("[FAIL] op %0d lst_inv_port: expected %h, got %h", idx, o.lst_port,
            lst_inv_port);
      end
      if (cmd_dropped !== exp_dropped)
      begin
         errors++;
         $display("[FAIL] op %0d cmd_dropped: expected %h, got %h", idx, exp_dropped,
            cmd_dropped);
      end
      if (check_busy !== 1'b0)
      begin
         errors++;
         $display("[FAIL] op %0d check_busy: expected %h, got %h", idx, 1'b0, check_busy);
      end
   endtask

   // ------------------------------------------------
   // main sequence
   // ------------------------------------------------
   initial
   begin
      cmd_write   = 1'b0;
      cmd         = cmd_none;
      cmd_data    = '0;
      mac_addr    = '0;
      d_addr      = '0;
      s_addr      = '0;
      s_port      = '0;
      curr_time   = '0;
      errors      = 0;
      exp_dropped = 1'b0;
      last_reused = 1'b0;
      seen        = '0;
      rng         = 32'hb9c9;
      load_testdata();
      loaded = 1'b1;
      wait (n_p_reset24 === 1'b1);
      @(negedge pclk24);
      foreach (ops[i])
      begin
         rng = xorshift(rng);
         repeat (rng[2:0]) @(negedge pclk24);   // idle gap 0 to 7
         mac_addr  = ops[i].mac;                 // held until the next op
         d_addr    = ops[i].d_addr;
         s_addr    = ops[i].s_addr;
         s_port    = ops[i].s_port;
         curr_time = ops[i].ctime;
         case (ops[i].op)
            op_check, op_overlap : run_check(ops[i]);
            op_clear :
            begin
               issue_cmd(cmd_clr_reused, ops[i].cdata);
               @(negedge pclk24);
               exp_dropped = 1'b0;
            end
            op_set_age :
            begin
               issue_cmd(cmd_set_age, ops[i].cdata);
               @(negedge pclk24);
            end
            op_peek : ;
            default :
            begin
               errors++;
               $display("unknown operation code in testdata line %0d", i);
            end
         endcase
         if (ops[i].op == op_overlap)
            exp_dropped = 1'b1;
         check_results(i, ops[i]);
         last_reused = ops[i].reused;
      end
      $display("operations: %0d, errors: %0d", ops.size(), errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // watchdog allows 30 cycles per op plus the reset
   initial
   begin
      wait (loaded);
      repeat (ops.size() * 30 + 4) @(posedge pclk24);
      $display("watchdog expired before all operations finished");
      $display("Regression failed");
      $finish;
   end

endmodule

// File: alut_lookup.f
+incdir+source
source/alut_pkg.sv
source/alut_cmd_decode.sv
source/alut_addr_checker.sv
source/alut_age_checker.sv
source/alut_mem.sv
source/alut_result.sv
source/alut_top.sv
tests/alut_clk_gen.sv
tests/alut_tb.sv

// File: Makefile
# Verilator build of the ALUT control side
# run from the project root, the testbench reads tests/alut_testdata.txt

VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = alut_tb
RTL_TOP   = alut_top
FILELIST  = alut_lookup.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# pass only when the run prints the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/alut_testdata.txt
# op mac d_addr s_addr s_port curr_time cmd_data | d_port reused lst_inv_addr lst_inv_port
# op 0 compare only, 1 check, 2 clear reused, 3 set max age, 4 check with a strobe while busy
0 02aabbccddee 000000000000 000000000000 0 00000000 00000000 0f 0 000000000000 0
3 02aabbccddee 000000000000 000000000000 0 00000000 00000100 0f 0 000000000000 0
1 02aabbccddee 02aabbccddee 000000000011 0 00000010 00000000 10 0 000000000000 0
1 02aabbccddee 000000000022 000000000011 1 00000020 00000000 0d 0 000000000000 0
1 02aabbccddee 000000000011 000000000022 2 00000030 00000000 02 0 000000000000 0
1 02aabbccddee 000000000011 000000000033 1 00000040 00000000 00 0 000000000000 0
1 02aabbccddee 000000000022 000000000033 1 00000130 00000000 0d 0 000000000000 0
1 02aabbccddee 000000000033 000000000011 3 000001f0 00000000 02 0 000000000000 0
1 02aabbccddee 000000000011 000000000110 0 00000200 00000000 08 1 000000000011 3
2 02aabbccddee 000000000011 000000000110 0 00000200 00000000 08 0 000000000011 3
4 02aabbccddee 000000000110 000000000022 2 00000210 00000000 01 0 000000000011 3
1 02aabbccddee 000000000011 000000000033 0 00000220 00000000 0e 0 000000000011 3
2 02aabbccddee 000000000011 000000000033 0 00000220 00000000 0e 0 000000000011 3
1 02aabbccddee 000000000022 000000000033 3 fffffff0 00000000 07 0 000000000011 3
1 02aabbccddee 000000000033 000000000022 0 00000010 00000000 08 0 000000000011 3
1 02aabbccddee 02aabbccddee 000000000110 1 00000018 00000000 10 0 000000000011 3
1 02aabbccddee 000000000033 000000000220 1 00000020 00000000 08 1 000000000022 0
2 02aabbccddee 000000000033 000000000220 1 00000020 00000000 08 0 000000000022 0
3 02aabbccddee 000000000033 000000000220 1 00000020 00000000 08 0 000000000022 0
1 02aabbccddee 000000000033 000000000011 2 00000020 00000000 0b 1 000000000110 0
